// File: design/ack_gap_enforcer.sv
// ACK gap enforcer: holds each RC ACK start until the spacing timer expires
`timescale 1ns/1ps
`include "roce_cfg.svh"

module ack_gap_enforcer (
  input  logic                    nclk,
  input  logic                    reset,
  input  roce_net_pkg::net_beat_t s_beat,
  input  logic                    s_valid,
  output logic                    s_ready,
  output roce_net_pkg::net_beat_t m_beat,
  output logic                    m_valid,
  input  logic                    m_ready
);

  import roce_net_pkg::*;

  localparam int GAP_BITS = $clog2(`ROCE_ACK_GAP + 1);

  logic                first_beat;
  bth_opcode_t         bth_opcode;
  logic                ack_start;
  logic                hold;
  logic [GAP_BITS-1:0] gap_cnt;

  // Opcode only means something on a packet's first beat
  assign bth_opcode = s_beat.data[`ROCE_BTH_OPCODE_LSB +: $bits(bth_opcode_t)];
  assign ack_start = first_beat && (bth_opcode == BTH_RC_ACK);

  // Stall only an ACK start while the gap runs
  assign hold = ack_start && (gap_cnt != '0);

  ////////////////////
  // Datapath
  ////////////////////

  // Beats pass straight through, packet order kept
  assign m_beat = s_beat;
  assign m_valid = s_valid && !hold;
  assign s_ready = m_ready && !hold;

  ////////////////////
  // Packet tracking
  ////////////////////

  always_ff @(posedge nclk) begin
    if (reset) begin
      first_beat <= 1'b1;
    end else if (m_valid && m_ready) begin
      // Next beat opens a packet after a last
      first_beat <= s_beat.last;
    end
  end

  // Gap timer, expired out of reset
  always_ff @(posedge nclk) begin
    if (reset) begin
      gap_cnt <= '0;
    end else if (m_valid && m_ready && ack_start) begin
      gap_cnt <= GAP_BITS'(`ROCE_ACK_GAP);
    end else if (gap_cnt != '0) begin
      gap_cnt <= gap_cnt - 1'b1;
    end
  end

endmodule

// File: design/meta_skid_buffer.sv
// Two-entry skid buffer for one metadata channel, input ready from a flop
`timescale 1ns/1ps

module meta_skid_buffer #(
  parameter int WIDTH = 32
) (
  input  logic             nclk,
  input  logic             reset,
  input  logic [WIDTH-1:0] s_data,
  input  logic             s_valid,
  output logic             s_ready,
  output logic [WIDTH-1:0] m_data,
  output logic             m_valid,
  input  logic             m_ready
);

  logic [WIDTH-1:0] skid_data;
  logic             skid_valid;

  // Ready drops one cycle after the skid slot fills
  assign s_ready = !skid_valid;

  // Control
  always_ff @(posedge nclk) begin
    if (reset) begin
      m_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else if (s_ready) begin
      if (!m_valid || m_ready) begin
        m_valid <= s_valid;
      end else begin
        // Main stalled, park the incoming word
        skid_valid <= s_valid;
      end
    end else if (m_ready) begin
      skid_valid <= 1'b0;
    end
  end

  // Payload, same enables as above
  always_ff @(posedge nclk) begin
    if (s_ready) begin
      if (!m_valid || m_ready) begin
        m_data <= s_data;
      end else begin
        skid_data <= s_data;
      end
    end else if (m_ready) begin
      m_data <= skid_data;
    end
  end

endmodule

// File: design/roce_cfg.svh
// RoCE shell configuration: field widths, RX buffering and ACK spacing
`ifndef ROCE_CFG_SVH
`define ROCE_CFG_SVH

// Network beat width, keep is one bit per byte
`define ROCE_NET_BITS 512

// User metadata field widths
`define ROCE_PID_BITS 6
`define ROCE_DEST_BITS 4
`define ROCE_STRM_BITS 2
`define ROCE_OFFS_BITS 6
`define ROCE_VADDR_BITS 48
`define ROCE_LEN_BITS 28
`define ROCE_OPCODE_BITS 5
`define ROCE_TIME_BITS 32

// Queue pair slot inside the stack words
`define ROCE_QPN_BITS 24

// RX ingress buffering
`define ROCE_RX_FIFO_DEPTH 16

// Min cycles between two ACK starts toward the stack
`define ROCE_ACK_GAP 85

// BTH opcode, byte 42 of the first beat
`define ROCE_BTH_OPCODE_LSB 336

`endif

// File: design/roce_meta_pkg.sv
// Metadata types on user and stack sides, with the pack and unpack functions
`include "roce_cfg.svh"

package roce_meta_pkg;

  // Layout of the stack words
  // Opcode at bit 0, queue pair number at bit 32
  localparam int QPN_LSB = 32;
  localparam int FIELD_LSB = QPN_LSB + `ROCE_QPN_BITS;
  // Address slot in the send queue word, wider than a user vaddr
  localparam int STACK_ADDR_BITS = 64;
  // Immediate holds 4 offset bits over the second length
  localparam int IMM_BITS = 4 + `ROCE_LEN_BITS;

  localparam int SQ_BITS = FIELD_LSB + 2 + `ROCE_OFFS_BITS + 2 * STACK_ADDR_BITS
                         + `ROCE_LEN_BITS + IMM_BITS;
  localparam int ACK_BITS = FIELD_LSB + 1 + `ROCE_DEST_BITS + `ROCE_STRM_BITS + 1
                          + `ROCE_TIME_BITS;
  localparam int CMD_BITS = FIELD_LSB + 1 + `ROCE_VADDR_BITS + `ROCE_DEST_BITS
                          + `ROCE_STRM_BITS + `ROCE_LEN_BITS + 2 + `ROCE_OFFS_BITS;

  // Raw memory mode, no parsing downstream
  localparam logic MODE_RAW = 1'b1;

  ////////////////////
  // User side
  ////////////////////

  typedef struct packed {
    logic [`ROCE_OPCODE_BITS-1:0] opcode;
    logic [`ROCE_PID_BITS-1:0]    pid;
    logic [`ROCE_DEST_BITS-1:0]   vfid;
    logic                         host;
    logic                         last;
    logic [`ROCE_OFFS_BITS-1:0]   offs;
    logic [`ROCE_VADDR_BITS-1:0]  vaddr;
    logic [`ROCE_DEST_BITS-1:0]   dest;
    logic [`ROCE_STRM_BITS-1:0]   strm;
    logic [`ROCE_LEN_BITS-1:0]    len;
  } dreq_half_t;

  // Local side in req_1, remote side in req_2
  typedef struct packed {
    dreq_half_t req_1;
    dreq_half_t req_2;
  } dreq_t;

  typedef struct packed {
    logic [`ROCE_OPCODE_BITS-1:0] opcode;
    logic                         remote;
    logic [`ROCE_PID_BITS-1:0]    pid;
    logic [`ROCE_DEST_BITS-1:0]   vfid;
    logic                         host;
    logic [`ROCE_DEST_BITS-1:0]   dest;
    logic [`ROCE_STRM_BITS-1:0]   strm;
    logic                         last;
    logic [`ROCE_TIME_BITS-1:0]   rtt_time;
  } dack_t;

  typedef struct packed {
    logic [`ROCE_OPCODE_BITS-1:0] opcode;
    logic                         mode;
    logic                         rdma;
    logic                         remote;
    logic [`ROCE_PID_BITS-1:0]    pid;
    logic [`ROCE_DEST_BITS-1:0]   vfid;
    logic                         last;
    logic [`ROCE_VADDR_BITS-1:0]  vaddr;
    logic [`ROCE_DEST_BITS-1:0]   dest;
    logic [`ROCE_STRM_BITS-1:0]   strm;
    logic [`ROCE_LEN_BITS-1:0]    len;
    logic                         actv;
    logic                         host;
    logic [`ROCE_OFFS_BITS-1:0]   offs;
  } mem_req_t;

  ////////////////////
  // Stack side
  ////////////////////

  typedef logic [SQ_BITS-1:0] sq_word_t;
  typedef logic [ACK_BITS-1:0] ack_word_t;
  typedef logic [CMD_BITS-1:0] cmd_word_t;

  // User request into the flat send queue word
  function automatic sq_word_t sq_pack(dreq_t req);
    sq_word_t w;
    int unsigned p;
    w = '0;
    w[0 +: `ROCE_OPCODE_BITS] = req.req_1.opcode;
    // Queue pair is pid with vfid above, zero-extended
    w[QPN_LSB +: `ROCE_QPN_BITS] = {req.req_1.vfid, req.req_1.pid};
    p = FIELD_LSB;
    w[p] = req.req_1.host;
    w[p + 1] = req.req_1.last;
    p = p + 2;
    w[p +: `ROCE_OFFS_BITS] = req.req_1.offs;
    p = p + `ROCE_OFFS_BITS;
    w[p +: STACK_ADDR_BITS] = req.req_1.vaddr;
    p = p + STACK_ADDR_BITS;
    // Remote address carries local dest and remote stream on top
    w[p +: STACK_ADDR_BITS] = {req.req_2.strm, req.req_1.dest, req.req_2.vaddr};
    p = p + STACK_ADDR_BITS;
    w[p +: `ROCE_LEN_BITS] = req.req_1.len;
    p = p + `ROCE_LEN_BITS;
    w[p +: IMM_BITS] = {req.req_2.offs[3:0], req.req_2.len};
    return w;
  endfunction

  // Flat ACK word into the user acknowledgement, always remote
  function automatic dack_t ack_unpack(ack_word_t w);
    dack_t a;
    int unsigned p;
    a.opcode = w[0 +: `ROCE_OPCODE_BITS];
    a.remote = 1'b1;
    a.pid = w[QPN_LSB +: `ROCE_PID_BITS];
    a.vfid = w[QPN_LSB + `ROCE_PID_BITS +: `ROCE_DEST_BITS];
    p = FIELD_LSB;
    a.host = w[p];
    p = p + 1;
    a.dest = w[p +: `ROCE_DEST_BITS];
    p = p + `ROCE_DEST_BITS;
    a.strm = w[p +: `ROCE_STRM_BITS];
    p = p + `ROCE_STRM_BITS;
    a.last = w[p];
    a.rtt_time = w[p + 1 +: `ROCE_TIME_BITS];
    return a;
  endfunction

  // Flat memory command into a raw local request
  function automatic mem_req_t cmd_unpack(cmd_word_t w);
    mem_req_t r;
    int unsigned p;
    r.opcode = w[0 +: `ROCE_OPCODE_BITS];
    r.mode = MODE_RAW;
    r.rdma = 1'b1;
    r.remote = 1'b0;
    r.pid = w[QPN_LSB +: `ROCE_PID_BITS];
    r.vfid = w[QPN_LSB + `ROCE_PID_BITS +: `ROCE_DEST_BITS];
    p = FIELD_LSB;
    r.last = w[p];
    p = p + 1;
    r.vaddr = w[p +: `ROCE_VADDR_BITS];
    p = p + `ROCE_VADDR_BITS;
    r.dest = w[p +: `ROCE_DEST_BITS];
    p = p + `ROCE_DEST_BITS;
    r.strm = w[p +: `ROCE_STRM_BITS];
    p = p + `ROCE_STRM_BITS;
    r.len = w[p +: `ROCE_LEN_BITS];
    p = p + `ROCE_LEN_BITS;
    r.actv = w[p];
    r.host = w[p + 1];
    r.offs = w[p + 2 +: `ROCE_OFFS_BITS];
    return r;
  endfunction

endpackage

// File: design/roce_net_pkg.sv
// Network side types for the RoCE RX ingress path
`include "roce_cfg.svh"

package roce_net_pkg;

  // One keep bit per data byte
  localparam int NET_KEEP_BITS = `ROCE_NET_BITS / 8;

  ////////////////////
  // RX beat
  ////////////////////

  // Data, byte enables and end of packet travel together
  typedef struct packed {
    logic [`ROCE_NET_BITS-1:0] data;
    logic [NET_KEEP_BITS-1:0]  keep;
    logic                      last;
  } net_beat_t;

  ////////////////////
  // BTH opcodes
  ////////////////////

  typedef logic [7:0] bth_opcode_t;

  // RC transport, acknowledge
  localparam bth_opcode_t BTH_RC_ACK = 8'h11;

endpackage

// File: design/roce_shell.sv
// RoCE integration shell: RX ingress path plus the metadata bridge to the stack
`timescale 1ns/1ps

module roce_shell (
  input  logic                     nclk,
  input  logic                     reset,
  // RX path
  input  roce_net_pkg::net_beat_t  s_rx,
  input  logic                     s_rx_valid,
  output logic                     s_rx_ready,
  output roce_net_pkg::net_beat_t  m_rx_stack,
  output logic                     m_rx_stack_valid,
  input  logic                     m_rx_stack_ready,
  // Send queue
  input  roce_meta_pkg::dreq_t     s_sq,
  input  logic                     s_sq_valid,
  output logic                     s_sq_ready,
  output roce_meta_pkg::sq_word_t  m_sq_stack,
  output logic                     m_sq_stack_valid,
  input  logic                     m_sq_stack_ready,
  // ACK
  input  roce_meta_pkg::ack_word_t s_ack_stack,
  input  logic                     s_ack_stack_valid,
  output logic                     s_ack_stack_ready,
  output roce_meta_pkg::dack_t     m_ack,
  output logic                     m_ack_valid,
  input  logic                     m_ack_ready,
  // Memory commands
  input  roce_meta_pkg::cmd_word_t s_rd_cmd_stack,
  input  logic                     s_rd_cmd_stack_valid,
  output logic                     s_rd_cmd_stack_ready,
  input  roce_meta_pkg::cmd_word_t s_wr_cmd_stack,
  input  logic                     s_wr_cmd_stack_valid,
  output logic                     s_wr_cmd_stack_ready,
  output roce_meta_pkg::mem_req_t  m_rd_req,
  output logic                     m_rd_req_valid,
  input  logic                     m_rd_req_ready,
  output roce_meta_pkg::mem_req_t  m_wr_req,
  output logic                     m_wr_req_valid,
  input  logic                     m_wr_req_ready
);

  import roce_net_pkg::*;

  // FIFO to gap enforcer
  net_beat_t fifo_to_gap;
  logic      fifo_to_gap_valid;
  logic      fifo_to_gap_ready;

  ////////////////////
  // RX ingress path
  ////////////////////

  // Absorbs beats while an ACK start is held back
  rx_packet_fifo inst_rx_fifo (
    .nclk(nclk), .reset(reset),
    .s_beat(s_rx), .s_valid(s_rx_valid), .s_ready(s_rx_ready),
    .m_beat(fifo_to_gap), .m_valid(fifo_to_gap_valid), .m_ready(fifo_to_gap_ready)
  );

  ack_gap_enforcer inst_ack_gap_enforcer (
    .nclk(nclk), .reset(reset),
    .s_beat(fifo_to_gap), .s_valid(fifo_to_gap_valid), .s_ready(fifo_to_gap_ready),
    .m_beat(m_rx_stack), .m_valid(m_rx_stack_valid), .m_ready(m_rx_stack_ready)
  );

  ////////////////////
  // Metadata channels
  ////////////////////

  stack_cmd_bridge inst_cmd_bridge (
    .nclk(nclk), .reset(reset),
    .s_sq(s_sq), .s_sq_valid(s_sq_valid), .s_sq_ready(s_sq_ready),
    .m_sq_stack(m_sq_stack), .m_sq_stack_valid(m_sq_stack_valid),
    .m_sq_stack_ready(m_sq_stack_ready),
    .s_ack_stack(s_ack_stack), .s_ack_stack_valid(s_ack_stack_valid),
    .s_ack_stack_ready(s_ack_stack_ready),
    .m_ack(m_ack), .m_ack_valid(m_ack_valid), .m_ack_ready(m_ack_ready),
    .s_rd_cmd_stack(s_rd_cmd_stack), .s_rd_cmd_stack_valid(s_rd_cmd_stack_valid),
    .s_rd_cmd_stack_ready(s_rd_cmd_stack_ready),
    .s_wr_cmd_stack(s_wr_cmd_stack), .s_wr_cmd_stack_valid(s_wr_cmd_stack_valid),
    .s_wr_cmd_stack_ready(s_wr_cmd_stack_ready),
    .m_rd_req(m_rd_req), .m_rd_req_valid(m_rd_req_valid), .m_rd_req_ready(m_rd_req_ready),
    .m_wr_req(m_wr_req), .m_wr_req_valid(m_wr_req_valid), .m_wr_req_ready(m_wr_req_ready)
  );

endmodule

// File: design/rx_packet_fifo.sv
// RX beat FIFO: circular buffer in front of a registered output stage
`timescale 1ns/1ps
`include "roce_cfg.svh"

module rx_packet_fifo (
  input  logic                    nclk,
  input  logic                    reset,
  input  roce_net_pkg::net_beat_t s_beat,
  input  logic                    s_valid,
  output logic                    s_ready,
  output roce_net_pkg::net_beat_t m_beat,
  output logic                    m_valid,
  input  logic                    m_ready
);

  import roce_net_pkg::*;

  // Depth is a power of two, pointers wrap on their own
  localparam int DEPTH = `ROCE_RX_FIFO_DEPTH;
  localparam int PTR_BITS = $clog2(DEPTH);
  localparam int CNT_BITS = $clog2(DEPTH + 1);

  net_beat_t           mem [DEPTH];
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [CNT_BITS-1:0] count;
  logic                push;
  logic                pop;

  // Back-pressure only once every slot holds a beat
  assign s_ready = (count != CNT_BITS'(DEPTH));
  assign push = s_valid && s_ready;

  // Move a beat out when the output stage is empty or draining
  assign pop = (count != '0) && (!m_valid || m_ready);

  ////////////////////
  // Pointers and count
  ////////////////////

  always_ff @(posedge nclk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      m_valid <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + CNT_BITS'(push) - CNT_BITS'(pop);
      // Refill wins over drain
      if (pop) begin
        m_valid <= 1'b1;
      end else if (m_ready) begin
        m_valid <= 1'b0;
      end
    end
  end

  ////////////////////
  // Storage
  ////////////////////

  always_ff @(posedge nclk) begin
    if (push) begin
      mem[wr_ptr] <= s_beat;
    end
    if (pop) begin
      m_beat <= mem[rd_ptr];
    end
  end

endmodule

// File: design/stack_cmd_bridge.sv
// Metadata bridge: converts and buffers the four user and stack channels
`timescale 1ns/1ps

module stack_cmd_bridge (
  input  logic                     nclk,
  input  logic                     reset,
  // Send queue
  input  roce_meta_pkg::dreq_t     s_sq,
  input  logic                     s_sq_valid,
  output logic                     s_sq_ready,
  output roce_meta_pkg::sq_word_t  m_sq_stack,
  output logic                     m_sq_stack_valid,
  input  logic                     m_sq_stack_ready,
  // ACK
  input  roce_meta_pkg::ack_word_t s_ack_stack,
  input  logic                     s_ack_stack_valid,
  output logic                     s_ack_stack_ready,
  output roce_meta_pkg::dack_t     m_ack,
  output logic                     m_ack_valid,
  input  logic                     m_ack_ready,
  // Memory commands
  input  roce_meta_pkg::cmd_word_t s_rd_cmd_stack,
  input  logic                     s_rd_cmd_stack_valid,
  output logic                     s_rd_cmd_stack_ready,
  input  roce_meta_pkg::cmd_word_t s_wr_cmd_stack,
  input  logic                     s_wr_cmd_stack_valid,
  output logic                     s_wr_cmd_stack_ready,
  output roce_meta_pkg::mem_req_t  m_rd_req,
  output logic                     m_rd_req_valid,
  input  logic                     m_rd_req_ready,
  output roce_meta_pkg::mem_req_t  m_wr_req,
  output logic                     m_wr_req_valid,
  input  logic                     m_wr_req_ready
);

  import roce_meta_pkg::*;

  sq_word_t sq_packed;
  dack_t    ack_decoded;
  mem_req_t rd_decoded;
  mem_req_t wr_decoded;

  // Conversion ahead of the buffers, pure wiring
  assign sq_packed = sq_pack(s_sq);
  assign ack_decoded = ack_unpack(s_ack_stack);
  assign rd_decoded = cmd_unpack(s_rd_cmd_stack);
  assign wr_decoded = cmd_unpack(s_wr_cmd_stack);

  ////////////////////
  // User to stack
  ////////////////////

  meta_skid_buffer #(.WIDTH($bits(sq_word_t))) inst_sq_buf (
    .nclk(nclk), .reset(reset),
    .s_data(sq_packed), .s_valid(s_sq_valid), .s_ready(s_sq_ready),
    .m_data(m_sq_stack), .m_valid(m_sq_stack_valid), .m_ready(m_sq_stack_ready)
  );

  ////////////////////
  // Stack to user
  ////////////////////

  meta_skid_buffer #(.WIDTH($bits(dack_t))) inst_ack_buf (
    .nclk(nclk), .reset(reset),
    .s_data(ack_decoded), .s_valid(s_ack_stack_valid), .s_ready(s_ack_stack_ready),
    .m_data(m_ack), .m_valid(m_ack_valid), .m_ready(m_ack_ready)
  );

  // Read and write commands run independently
  meta_skid_buffer #(.WIDTH($bits(mem_req_t))) inst_rd_buf (
    .nclk(nclk), .reset(reset),
    .s_data(rd_decoded), .s_valid(s_rd_cmd_stack_valid), .s_ready(s_rd_cmd_stack_ready),
    .m_data(m_rd_req), .m_valid(m_rd_req_valid), .m_ready(m_rd_req_ready)
  );

  meta_skid_buffer #(.WIDTH($bits(mem_req_t))) inst_wr_buf (
    .nclk(nclk), .reset(reset),
    .s_data(wr_decoded), .s_valid(s_wr_cmd_stack_valid), .s_ready(s_wr_cmd_stack_ready),
    .m_data(m_wr_req), .m_valid(m_wr_req_valid), .m_ready(m_wr_req_ready)
  );

endmodule

// File: roce_shell.f
+incdir+design
design/roce_net_pkg.sv
design/roce_meta_pkg.sv
design/rx_packet_fifo.sv
design/ack_gap_enforcer.sv
design/meta_skid_buffer.sv
design/stack_cmd_bridge.sv
design/roce_shell.sv
verif/roce_shell_tb.sv

// File: verif/roce_shell_tb.sv
// Testbench for the RoCE shell: random traffic on every channel against a reference model
`timescale 1ns/1ps
`include "roce_cfg.svh"

module roce_shell_tb;

  import roce_net_pkg::*;
  import roce_meta_pkg::*;

  localparam int N_PKT = 40;
  localparam int N_META = 60;
  localparam int RESET_CYCLES = 16;
  localparam int DRAIN_CYCLES = 20;
  // Wide enough for a whole RX beat
  localparam int WIDE = 640;

  logic      nclk;
  logic      reset;
  net_beat_t s_rx;
  logic      s_rx_valid;
  logic      s_rx_ready;
  net_beat_t m_rx_stack;
  logic      m_rx_stack_valid;
  logic      m_rx_stack_ready;
  dreq_t     s_sq;
  logic      s_sq_valid;
  logic      s_sq_ready;
  sq_word_t  m_sq_stack;
  logic      m_sq_stack_valid;
  logic      m_sq_stack_ready;
  ack_word_t s_ack_stack;
  logic      s_ack_stack_valid;
  logic      s_ack_stack_ready;
  dack_t     m_ack;
  logic      m_ack_valid;
  logic      m_ack_ready;
  cmd_word_t s_rd_cmd_stack;
  logic      s_rd_cmd_stack_valid;
  logic      s_rd_cmd_stack_ready;
  cmd_word_t s_wr_cmd_stack;
  logic      s_wr_cmd_stack_valid;
  logic      s_wr_cmd_stack_ready;
  mem_req_t  m_rd_req;
  logic      m_rd_req_valid;
  logic      m_rd_req_ready;
  mem_req_t  m_wr_req;
  logic      m_wr_req_valid;
  logic      m_wr_req_ready;

  // Model queues, one per output channel
  net_beat_t rx_q[$];
  sq_word_t  sq_q[$];
  dack_t     ack_q[$];
  mem_req_t  rd_q[$];
  mem_req_t  wr_q[$];

  // Packet plan and progress
  int          pkt_len[N_PKT];
  bit          pkt_ack[N_PKT];
  int          pkt_idx;
  int          beat_idx;
  int          sq_sent;
  int          ack_sent;
  int          rd_sent;
  int          wr_sent;
  int          cycle;
  int          last_ack_cycle;
  bit          out_first;
  int          checks;
  int          errors;
  logic [31:0] rng_state;

  roce_shell i_dut (.*);

  initial begin
    nclk = 1'b0;
    forever begin
      #4 nclk = ~nclk;
    end
  end

  ////////////////////
  // Helpers
  ////////////////////

  // xorshift32
  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic logic [WIDE-1:0] rand_wide();
    logic [WIDE-1:0] v;
    for (int i = 0; i < WIDE / 32; i++) begin
      v[i*32 +: 32] = next_rand();
    end
    return v;
  endfunction

  function automatic net_beat_t make_beat(bit first, bit is_ack, bit last);
    logic [WIDE-1:0] r;
    net_beat_t       b;
    r = rand_wide();
    b = r[$bits(net_beat_t)-1:0];
    if (first) begin
      if (is_ack) begin
        b.data[`ROCE_BTH_OPCODE_LSB +: 8] = BTH_RC_ACK;
      end else if (b.data[`ROCE_BTH_OPCODE_LSB +: 8] == BTH_RC_ACK) begin
        // RC send only
        b.data[`ROCE_BTH_OPCODE_LSB +: 8] = 8'h04;
      end
    end
    b.last = last;
    return b;
  endfunction

  ////////////////////
  // Reference model
  ////////////////////

  // Send queue word from bit 0: opcode, pad to 32, qpn, host, last, offs,
  // local vaddr in 64, {strm, dest, remote vaddr} in 64, len, immediate
  function automatic sq_word_t model_sq(dreq_t r);
    return {r.req_2.offs[3:0], r.req_2.len, r.req_1.len,
            10'b0, r.req_2.strm, r.req_1.dest, r.req_2.vaddr,
            16'b0, r.req_1.vaddr,
            r.req_1.offs, r.req_1.last, r.req_1.host,
            14'b0, r.req_1.vfid, r.req_1.pid,
            27'b0, r.req_1.opcode};
  endfunction

  // ACK word, fields from bit 56: host, dest, strm, last, rtt
  function automatic dack_t model_ack(ack_word_t w);
    return {w[4:0], 1'b1, w[37:32], w[41:38], w[56], w[60:57], w[62:61], w[63],
            w[95:64]};
  endfunction

  // Command word, fields from bit 56: last, vaddr, dest, strm, len, actv, host, offs
  function automatic mem_req_t model_cmd(cmd_word_t w);
    return {w[4:0], MODE_RAW, 1'b1, 1'b0, w[37:32], w[41:38], w[56], w[104:57],
            w[108:105], w[110:109], w[138:111], w[139], w[140], w[146:141]};
  endfunction

  ////////////////////
  // Checks
  ////////////////////

  task automatic check_value(string name, logic [WIDE-1:0] expected, logic [WIDE-1:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[ERROR] t=%0t %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic report_extra(string name);
    errors++;
    $display("Output on %s at %0t with no item pending in the model", name, $time);
  endtask

  function automatic bit all_done();
    return pkt_idx == N_PKT && sq_sent == N_META && ack_sent == N_META
      && rd_sent == N_META && wr_sent == N_META && rx_q.size() == 0
      && sq_q.size() == 0 && ack_q.size() == 0 && rd_q.size() == 0 && wr_q.size() == 0;
  endfunction

  ////////////////////
  // One clock cycle
  ////////////////////

  // Samples handshakes on the edge, then drives 1 ns later
  task automatic step_cycle(bit run);
    logic [WIDE-1:0] r;
    net_beat_t       exp_beat;
    bit              rx_acc;
    bit              sq_acc;
    bit              ack_acc;
    bit              rd_acc;
    bit              wr_acc;
    @(posedge nclk);
    cycle++;
    rx_acc = s_rx_valid && s_rx_ready;
    sq_acc = s_sq_valid && s_sq_ready;
    ack_acc = s_ack_stack_valid && s_ack_stack_ready;
    rd_acc = s_rd_cmd_stack_valid && s_rd_cmd_stack_ready;
    wr_acc = s_wr_cmd_stack_valid && s_wr_cmd_stack_ready;
    // No output may be valid while reset is held
    if (reset && cycle > 1) begin
      check_value("m_rx_stack_valid", '0, WIDE'(m_rx_stack_valid));
      check_value("m_sq_stack_valid", '0, WIDE'(m_sq_stack_valid));
      check_value("m_ack_valid", '0, WIDE'(m_ack_valid));
      check_value("m_rd_req_valid", '0, WIDE'(m_rd_req_valid));
      check_value("m_wr_req_valid", '0, WIDE'(m_wr_req_valid));
    end
    // Accepted inputs go into the model
    if (rx_acc) begin
      rx_q.push_back(s_rx);
      beat_idx++;
      if (beat_idx == pkt_len[pkt_idx]) begin
        beat_idx = 0;
        pkt_idx++;
      end
    end
    if (sq_acc) begin
      sq_q.push_back(model_sq(s_sq));
      sq_sent++;
    end
    if (ack_acc) begin
      ack_q.push_back(model_ack(s_ack_stack));
      ack_sent++;
    end
    if (rd_acc) begin
      rd_q.push_back(model_cmd(s_rd_cmd_stack));
      rd_sent++;
    end
    if (wr_acc) begin
      wr_q.push_back(model_cmd(s_wr_cmd_stack));
      wr_sent++;
    end
    // Outputs against the model
    if (m_rx_stack_valid && m_rx_stack_ready) begin
      if (rx_q.size() == 0) begin
        report_extra("m_rx_stack");
      end else begin
        exp_beat = rx_q.pop_front();
        check_value("m_rx_stack", WIDE'(exp_beat), WIDE'(m_rx_stack));
        if (out_first && exp_beat.data[`ROCE_BTH_OPCODE_LSB +: 8] == BTH_RC_ACK) begin
          if (last_ack_cycle >= 0 && cycle - last_ack_cycle < `ROCE_ACK_GAP) begin
            errors++;
            $display("ACK start at %0t only %0d cycles after the previous one",
                     $time, cycle - last_ack_cycle);
          end
          last_ack_cycle = cycle;
        end
        out_first = exp_beat.last;
      end
    end
    if (m_sq_stack_valid && m_sq_stack_ready) begin
      if (sq_q.size() == 0) report_extra("m_sq_stack");
      else check_value("m_sq_stack", WIDE'(sq_q.pop_front()), WIDE'(m_sq_stack));
    end
    if (m_ack_valid && m_ack_ready) begin
      if (ack_q.size() == 0) report_extra("m_ack");
      else check_value("m_ack", WIDE'(ack_q.pop_front()), WIDE'(m_ack));
    end
    if (m_rd_req_valid && m_rd_req_ready) begin
      if (rd_q.size() == 0) report_extra("m_rd_req");
      else check_value("m_rd_req", WIDE'(rd_q.pop_front()), WIDE'(m_rd_req));
    end
    if (m_wr_req_valid && m_wr_req_ready) begin
      if (wr_q.size() == 0) report_extra("m_wr_req");
      else check_value("m_wr_req", WIDE'(wr_q.pop_front()), WIDE'(m_wr_req));
    end
    #1;
    // Sources hold data until accepted
    if (!s_rx_valid || rx_acc) begin
      s_rx_valid = 1'b0;
      if (run && pkt_idx < N_PKT && (next_rand() % 4) != 0) begin
        s_rx = make_beat(beat_idx == 0, pkt_ack[pkt_idx], beat_idx == pkt_len[pkt_idx] - 1);
        s_rx_valid = 1'b1;
      end
    end
    if (!s_sq_valid || sq_acc) begin
      r = rand_wide();
      s_sq = r[$bits(dreq_t)-1:0];
      s_sq_valid = run && sq_sent < N_META && (next_rand() % 2) == 0;
    end
    if (!s_ack_stack_valid || ack_acc) begin
      r = rand_wide();
      s_ack_stack = r[$bits(ack_word_t)-1:0];
      s_ack_stack_valid = run && ack_sent < N_META && (next_rand() % 2) == 0;
    end
    if (!s_rd_cmd_stack_valid || rd_acc) begin
      r = rand_wide();
      s_rd_cmd_stack = r[$bits(cmd_word_t)-1:0];
      s_rd_cmd_stack_valid = run && rd_sent < N_META && (next_rand() % 2) == 0;
    end
    if (!s_wr_cmd_stack_valid || wr_acc) begin
      r = rand_wide();
      s_wr_cmd_stack = r[$bits(cmd_word_t)-1:0];
      s_wr_cmd_stack_valid = run && wr_sent < N_META && (next_rand() % 2) == 0;
    end
    // Random downstream stalls
    m_rx_stack_ready = (next_rand() % 4) != 0;
    m_sq_stack_ready = (next_rand() % 4) != 0;
    m_ack_ready = (next_rand() % 4) != 0;
    m_rd_req_ready = (next_rand() % 4) != 0;
    m_wr_req_ready = (next_rand() % 4) != 0;
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    int beats;
    int acks;
    int limit;
    bit timed_out;
    rng_state = 32'h55d9;
    reset = 1'b1;
    s_rx = '0;
    s_rx_valid = 1'b0;
    m_rx_stack_ready = 1'b0;
    s_sq = '0;
    s_sq_valid = 1'b0;
    m_sq_stack_ready = 1'b0;
    s_ack_stack = '0;
    s_ack_stack_valid = 1'b0;
    m_ack_ready = 1'b0;
    s_rd_cmd_stack = '0;
    s_rd_cmd_stack_valid = 1'b0;
    s_wr_cmd_stack = '0;
    s_wr_cmd_stack_valid = 1'b0;
    m_rd_req_ready = 1'b0;
    m_wr_req_ready = 1'b0;
    pkt_idx = 0;
    beat_idx = 0;
    sq_sent = 0;
    ack_sent = 0;
    rd_sent = 0;
    wr_sent = 0;
    cycle = 0;
    last_ack_cycle = -1;
    out_first = 1'b1;
    checks = 0;
    errors = 0;
    timed_out = 1'b0;
    // Packets of 1 to 4 beats, about a third of them ACKs
    beats = 0;
    acks = 0;
    for (int i = 0; i < N_PKT; i++) begin
      pkt_len[i] = 1 + int'(next_rand() % 4);
      pkt_ack[i] = (next_rand() % 3) == 0;
      beats += pkt_len[i];
      acks += int'(pkt_ack[i]);
    end
    limit = 4 * (beats + `ROCE_ACK_GAP * acks) + 4 * 4 * N_META;
    repeat (RESET_CYCLES) step_cycle(1'b0);
    reset = 1'b0;
    cycle = 0;
    while (!all_done()) begin
      if (cycle >= limit) begin
        timed_out = 1'b1;
        break;
      end
      step_cycle(1'b1);
    end
    // Idle tail catches stray outputs
    if (!timed_out) begin
      repeat (DRAIN_CYCLES) step_cycle(1'b1);
    end else begin
      errors++;
      $display("Timeout after %0d cycles: %0d of %0d packets sent, pending rx %0d sq %0d",
               cycle, pkt_idx, N_PKT, rx_q.size(), sq_q.size());
      $display("Still pending: ack %0d rd %0d wr %0d, sent sq %0d ack %0d rd %0d wr %0d",
               ack_q.size(), rd_q.size(), wr_q.size(), sq_sent, ack_sent, rd_sent, wr_sent);
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
